/* Bender.yml */
package:
  name: fetchStage

sources:
  - fetchPkg.sv
  - cacheReqIf.sv
  - pcGen.sv
  - iCache.sv
  - ifIdReg.sv
  - fetchTop.sv
  - target: simulation
    files:
      - tbFetchTop.sv

/* cacheReqIf.sv */
interface cacheReqIf import fetchPkg::*; ();

    // Request side, driven by the PC generator.
    logic                 valid;
    logic [addrWidth-1:0] addr;

    // Response side, driven by the cache.
    logic                 ready;
    logic [dataWidth-1:0] rdata;

    modport producer (
        output valid,
        output addr,
        input  ready,
        input  rdata
    );

    modport cache (
        input  valid,
        input  addr,
        output ready,
        output rdata
    );

    // Read-only view for the fetch/decode register.
    modport monitor (
        input valid,
        input addr,
        input ready,
        input rdata
    );

endinterface

/* compile.f */
fetchPkg.sv
cacheReqIf.sv
pcGen.sv
iCache.sv
ifIdReg.sv
fetchTop.sv
tbFetchTop.sv

/* fetchPkg.sv */
package fetchPkg;

    ////////////////////////////////////////
    // Datapath widths.
    ////////////////////////////////////////

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // Boot ROM entry and general exception entry.
    localparam logic [addrWidth-1:0] resetVector = 32'hBFC0_0000;
    localparam logic [addrWidth-1:0] excVector   = 32'hBFC0_0380;

    ////////////////////////////////////////
    // Instruction cache geometry.
    ////////////////////////////////////////

    localparam int lineWords  = 4;
    localparam int numLines   = 16;

    // Address split: tag | index | byte offset.
    localparam int offsetBits = 4;
    localparam int indexBits  = 4;
    localparam int tagBits    = 24;

    ////////////////////////////////////////
    // Enumerations.
    ////////////////////////////////////////

    // Source of the next fetch address.
    typedef enum logic [2:0] {
        pcSeq    = 3'd0,
        pcJump   = 3'd1,
        pcBranch = 3'd2,
        pcExcept = 3'd3,
        pcEret   = 3'd4,
        pcReg    = 3'd5
    } pcSrcE;

    // Cache controller states.
    typedef enum logic [1:0] {
        stLookup = 2'd0,
        stRefill = 2'd1,
        stFill   = 2'd2
    } cacheStateE;

endpackage

/* fetchTop.sv */
module fetchTop import fetchPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  pcSrcE                redirSrc,
    input  logic [25:0]          jumpIndex,
    input  logic [addrWidth-1:0] exePc,
    input  logic [addrWidth-1:0] exeImm,
    input  logic [addrWidth-1:0] regTarget,
    input  logic [addrWidth-1:0] epc,
    input  logic                 idStall,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [addrWidth-1:0] wbAdr,
    input  logic [dataWidth-1:0] wbDatI,
    input  logic                 wbAck,
    output logic                 idValid,
    output logic [addrWidth-1:0] idPc,
    output logic [dataWidth-1:0] idInstr
);

    logic flush;

    cacheReqIf fetchReq ();

    // Any redirect squashes the word accepted in the same cycle.
    assign flush = (redirSrc != pcSeq);

    // Fetch port is read only.
    assign wbWe = 1'b0;

    pcGen u_pcGen (
        .clk       (clk),
        .rstN      (rstN),
        .redirSrc  (redirSrc),
        .jumpIndex (jumpIndex),
        .exePc     (exePc),
        .exeImm    (exeImm),
        .regTarget (regTarget),
        .epc       (epc),
        .idStall   (idStall),
        .req       (fetchReq.producer)
    );

    iCache u_iCache (
        .clk    (clk),
        .rstN   (rstN),
        .req    (fetchReq.cache),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbAdr  (wbAdr),
        .wbDatI (wbDatI),
        .wbAck  (wbAck)
    );

    ifIdReg u_ifIdReg (
        .clk     (clk),
        .rstN    (rstN),
        .req     (fetchReq.monitor),
        .idStall (idStall),
        .flush   (flush),
        .idValid (idValid),
        .idPc    (idPc),
        .idInstr (idInstr)
    );

endmodule

/* iCache.sv */
module iCache import fetchPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    cacheReqIf.cache             req,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic [addrWidth-1:0] wbAdr,
    input  logic [dataWidth-1:0] wbDatI,
    input  logic                 wbAck
);

    cacheStateE state;

    // Storage arrays.
    logic [tagBits-1:0]   tagArr   [numLines];
    logic [dataWidth-1:0] dataArr  [numLines][lineWords];
    logic [numLines-1:0]  validArr;

    // Request address fields.
    logic [tagBits-1:0]      reqTag;
    logic [indexBits-1:0]    reqIndex;
    logic [offsetBits-3:0]   reqWord;
    logic                    hit;
    logic                    missStart;

    // Refill bookkeeping.
    logic [addrWidth-offsetBits-1:0] lineAddr;
    logic [indexBits-1:0]            lineIndex;
    logic [tagBits-1:0]              lineTag;
    logic [offsetBits-3:0]           wordCnt;

    ////////////////////////////////////////
    // Lookup.
    ////////////////////////////////////////

    assign reqTag   = req.addr[addrWidth-1 -: tagBits];
    assign reqIndex = req.addr[offsetBits +: indexBits];
    assign reqWord  = req.addr[2 +: offsetBits-2];

    // Purely combinational on the current address.
    assign hit       = validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
    assign req.ready = (state == stLookup) && hit;
    assign req.rdata = dataArr[reqIndex][reqWord];

    assign missStart = (state == stLookup) && req.valid && !hit;

    assign lineIndex = lineAddr[indexBits-1:0];
    assign lineTag   = lineAddr[indexBits +: tagBits];

    ////////////////////////////////////////
    // Wishbone master.
    ////////////////////////////////////////

    // One cycle for the whole line, strobe held across words.
    assign wbCyc = (state == stRefill);
    assign wbStb = wbCyc;
    assign wbAdr = {lineAddr, wordCnt, 2'b00};

    ////////////////////////////////////////
    // Controller.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= stLookup;
            wordCnt  <= '0;
            validArr <= '0;
        end else begin
            unique case (state)
                stLookup: begin
                    if (missStart) begin
                        // Victim line is unusable until the fill ends.
                        validArr[reqIndex] <= 1'b0;
                        wordCnt            <= '0;
                        state              <= stRefill;
                    end
                end
                stRefill: begin
                    if (wbAck) begin
                        wordCnt <= wordCnt + 1'b1;
                        if (&wordCnt) begin
                            state <= stFill;
                        end
                    end
                end
                stFill: begin
                    validArr[lineIndex] <= 1'b1;
                    state               <= stLookup;
                end
                default: state <= stLookup;
            endcase
        end
    end

    // Line address, tags and data.
    always_ff @(posedge clk) begin
        if (missStart) begin
            lineAddr <= req.addr[addrWidth-1:offsetBits];
        end
        if (state == stRefill && wbAck) begin
            dataArr[lineIndex][wordCnt] <= wbDatI;
        end
        if (state == stFill) begin
            tagArr[lineIndex] <= lineTag;
        end
    end

    ////////////////////////////////////////
    // Bus checks.
    ////////////////////////////////////////

    stbInCyc: assert property (
        @(posedge clk) disable iff (!rstN)
        wbStb |-> wbCyc
    ) else $error("iCache: wbStb high outside wbCyc");

    adrStable: assert property (
        @(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> $stable(wbAdr)
    ) else $error("iCache: wbAdr changed before wbAck");

endmodule

/* ifIdReg.sv */
module ifIdReg import fetchPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    cacheReqIf.monitor           req,
    input  logic                 idStall,
    input  logic                 flush,
    output logic                 idValid,
    output logic [addrWidth-1:0] idPc,
    output logic [dataWidth-1:0] idInstr
);

    logic accepted;

    assign accepted = req.valid & req.ready;

    // Valid flag. Flush beats stall.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idValid <= 1'b0;
        end else if (flush) begin
            idValid <= 1'b0;
        end else if (!idStall) begin
            idValid <= accepted;
        end
    end

    // Payload only moves on an accepted fetch.
    always_ff @(posedge clk) begin
        if (!idStall && accepted) begin
            idPc    <= req.addr;
            idInstr <= req.rdata;
        end
    end

    // The word fetched alongside a redirect must not reach decode.
    flushKills: assert property (
        @(posedge clk) disable iff (!rstN)
        flush |=> !idValid
    ) else $error("ifIdReg: idValid high after flush");

endmodule

/* pcGen.sv */
module pcGen import fetchPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  pcSrcE                redirSrc,
    input  logic [25:0]          jumpIndex,
    input  logic [addrWidth-1:0] exePc,
    input  logic [addrWidth-1:0] exeImm,
    input  logic [addrWidth-1:0] regTarget,
    input  logic [addrWidth-1:0] epc,
    input  logic                 idStall,
    cacheReqIf.producer          req
);

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] pcPlus4;
    logic [addrWidth-1:0] jumpTarget;
    logic [addrWidth-1:0] branchTarget;
    logic [addrWidth-1:0] nextPc;
    logic                 accepted;

    ////////////////////////////////////////
    // Fetch request.
    ////////////////////////////////////////

    assign req.addr  = pc;
    assign req.valid = ~idStall;
    assign accepted  = req.valid & req.ready;

    ////////////////////////////////////////
    // Target arithmetic.
    ////////////////////////////////////////

    assign pcPlus4 = pc + 32'd4;

    // J/JAL: region bits of the delay slot address.
    assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

    // Word offset relative to the branch delay slot.
    assign branchTarget = exePc + 32'd4 + {exeImm[29:0], 2'b00};

    // Next-PC select.
    always_comb begin
        unique case (redirSrc)
            pcSeq:    nextPc = accepted ? pcPlus4 : pc;
            pcJump:   nextPc = jumpTarget;
            pcBranch: nextPc = branchTarget;
            pcExcept: nextPc = excVector;
            pcEret:   nextPc = epc;
            pcReg:    nextPc = regTarget;
            default:  nextPc = pc;
        endcase
    end

    ////////////////////////////////////////
    // Program counter.
    ////////////////////////////////////////

    // A redirect wins over stall and over a pending refill.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetVector;
        end else begin
            pc <= nextPc;
        end
    end

    // Every source, including register and EPC targets, must stay word aligned.
    addrAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        req.addr[1:0] == 2'b00
    ) else $error("pcGen: fetch address %h not word aligned", req.addr);

endmodule

/* tbFetchTop.sv */
module tbFetchTop import fetchPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 rstN;
    pcSrcE                redirSrc;
    logic [25:0]          jumpIndex;
    logic [addrWidth-1:0] exePc;
    logic [addrWidth-1:0] exeImm;
    logic [addrWidth-1:0] regTarget;
    logic [addrWidth-1:0] epc;
    logic                 idStall;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [addrWidth-1:0] wbAdr;
    logic [dataWidth-1:0] wbDatI;
    logic                 wbAck;
    logic                 idValid;
    logic [addrWidth-1:0] idPc;
    logic [dataWidth-1:0] idInstr;

    // Bus monitor bookkeeping.
    int                   cycStarts = 0;
    int                   ackCnt    = 0;
    logic                 cycSeen   = 1'b0;
    logic [addrWidth-1:0] lineBase;

    // One redirect per row, with the first word expected after it.
    typedef struct packed {
        pcSrcE                src;
        logic [25:0]          jIdx;
        logic [addrWidth-1:0] exePc;
        logic [addrWidth-1:0] exeImm;
        logic [addrWidth-1:0] regTarget;
        logic [addrWidth-1:0] epc;
        logic                 noBus;
        logic [addrWidth-1:0] expPc;
        logic [dataWidth-1:0] expInstr;
    } redirRowT;

    redirRowT rows [7];

    fetchTop i_fetchTop (
        .clk       (clk),
        .rstN      (rstN),
        .redirSrc  (redirSrc),
        .jumpIndex (jumpIndex),
        .exePc     (exePc),
        .exeImm    (exeImm),
        .regTarget (regTarget),
        .epc       (epc),
        .idStall   (idStall),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatI    (wbDatI),
        .wbAck     (wbAck),
        .idValid   (idValid),
        .idPc      (idPc),
        .idInstr   (idInstr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic abortOnTimeout(input string what);
        $display("Timeout: no %s within 200 cycles", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // Waits for the next word at decode, sampled on the falling edge.
    task automatic nextWord(output logic [31:0] pc, output logic [31:0] instr,
                            output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!idValid && waited < 200);
        if (!idValid) begin
            abortOnTimeout("accepted fetch at the decode register");
        end
        pc    = idPc;
        instr = idInstr;
        // Memory data is the inverted address.
        checkEq("idInstr", idInstr, ~idPc);
    endtask

    // Holds the redirect for exactly one cycle.
    task automatic applyRedirect(input redirRowT r);
        @(posedge clk);
        #2;
        redirSrc  = r.src;
        jumpIndex = r.jIdx;
        exePc     = r.exePc;
        exeImm    = r.exeImm;
        regTarget = r.regTarget;
        epc       = r.epc;
        @(posedge clk);
        #2;
        redirSrc = pcSeq;
        // Word taken in the redirect cycle is squashed.
        checkEq("idValid", idValid, 1'b0);
    endtask

    ////////////////////////////////////////
    // Memory model and bus monitor.
    ////////////////////////////////////////

    // Answers each read after 0 to 3 wait cycles.
    initial begin : memModel
        int delay;
        wbAck  = 1'b0;
        wbDatI = '0;
        void'($urandom(66));
        delay = $urandom_range(3, 0);
        forever begin
            @(posedge clk);
            #2;
            wbAck = 1'b0;
            if (wbCyc && wbStb) begin
                if (delay == 0) begin
                    wbAck  = 1'b1;
                    wbDatI = ~wbAdr;
                    delay  = $urandom_range(3, 0);
                end else begin
                    delay--;
                end
            end
        end
    end

    // A refill is one wbCyc period of four ascending word reads.
    always @(negedge clk) begin
        if (rstN) begin
            // Read only port, strobe held for the whole refill.
            checkEq("wbWe", wbWe, 1'b0);
            checkEq("wbStb", wbStb, wbCyc);
            if (wbCyc && !cycSeen) begin
                cycStarts++;
                ackCnt = 0;
            end
            if (wbCyc && wbAck) begin
                if (ackCnt == 0) begin
                    lineBase = wbAdr;
                    checkEq("wbAdr line offset", wbAdr[3:0], 4'h0);
                end
                checkEq("wbAdr", wbAdr, lineBase + 4 * ackCnt);
                ackCnt++;
            end
            if (!wbCyc && cycSeen) begin
                checkEq("acks per wbCyc", ackCnt, 4);
            end
            cycSeen = wbCyc;
        end
    end

    ////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////

    initial begin : mainSeq
        logic [addrWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
        logic [addrWidth-1:0] heldPc;
        logic [dataWidth-1:0] heldInstr;
        logic                 heldValid;
        int                   waited;
        int                   snap;

        rstN      = 1'b0;
        redirSrc  = pcSeq;
        jumpIndex = '0;
        exePc     = '0;
        exeImm    = '0;
        regTarget = '0;
        epc       = '0;
        idStall   = 1'b0;

        // Unused operands point elsewhere, so a wrong source shows up.
        rows[0] = '{pcReg, 26'h0, 32'hBFC0_0A00, 32'h0, 32'hBFC0_0000, 32'hBFC0_0C00,
                    1'b1, 32'hBFC0_0000, ~32'hBFC0_0000};
        rows[1] = '{pcJump, 26'h3F0_0100, 32'hBFC0_0A00, 32'h0, 32'hBFC0_0B00, 32'hBFC0_0C00,
                    1'b0, 32'hBFC0_0400, ~32'hBFC0_0400};
        rows[2] = '{pcBranch, 26'h0, 32'hBFC0_0400, 32'h20, 32'hBFC0_0B00, 32'hBFC0_0C00,
                    1'b0, 32'hBFC0_0484, ~32'hBFC0_0484};
        rows[3] = '{pcBranch, 26'h0, 32'hBFC0_0484, 32'hFFFF_FFF0, 32'hBFC0_0B00, 32'hBFC0_0C00,
                    1'b0, 32'hBFC0_0448, ~32'hBFC0_0448};
        rows[4] = '{pcExcept, 26'h0, 32'hBFC0_0A00, 32'h0, 32'hBFC0_0B00, 32'hBFC0_0C00,
                    1'b0, 32'hBFC0_0380, ~32'hBFC0_0380};
        rows[5] = '{pcEret, 26'h0, 32'hBFC0_0A00, 32'h0, 32'hBFC0_0B00, 32'hBFC0_0108,
                    1'b0, 32'hBFC0_0108, ~32'hBFC0_0108};
        rows[6] = '{pcReg, 26'h0, 32'hBFC0_0A00, 32'h0, 32'hBFC0_0384, 32'hBFC0_0C00,
                    1'b1, 32'hBFC0_0384, ~32'hBFC0_0384};

        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;

        // Bus idle and decode empty out of reset.
        checkEq("wbCyc", wbCyc, 1'b0);
        checkEq("wbStb", wbStb, 1'b0);
        checkEq("idValid", idValid, 1'b0);

        // Boot stream covers two lines.
        for (int i = 0; i < 8; i++) begin
            nextWord(pc, instr, waited);
            checkEq("idPc", pc, resetVector + 4 * i);
        end
        checkEq("wbCyc periods", cycStarts, 2);

        for (int i = 0; i < $size(rows); i++) begin
            applyRedirect(rows[i]);
            snap = cycStarts;
            nextWord(pc, instr, waited);
            checkEq("idPc", pc, rows[i].expPc);
            checkEq("idInstr", instr, rows[i].expInstr);
            for (int k = 1; k <= 2; k++) begin
                nextWord(pc, instr, waited);
                checkEq("idPc", pc, rows[i].expPc + 4 * k);
                // Hits arrive back to back.
                if (rows[i].noBus) begin
                    checkEq("cycles between hits", waited, 1);
                end
            end
            if (rows[i].noBus) begin
                checkEq("wbCyc periods", cycStarts, snap);
            end
        end

        // Decode back-pressure.
        nextWord(pc, instr, waited);
        @(posedge clk);
        #2;
        idStall   = 1'b1;
        heldPc    = pc + 4;
        heldInstr = ~heldPc;
        heldValid = 1'b1;
        repeat (5) begin
            @(negedge clk);
            checkEq("idPc", idPc, heldPc);
            checkEq("idInstr", idInstr, heldInstr);
            checkEq("idValid", idValid, heldValid);
        end
        @(posedge clk);
        #2;
        idStall = 1'b0;
        @(posedge clk);
        for (int i = 1; i <= 4; i++) begin
            nextWord(pc, instr, waited);
            checkEq("idPc", pc, heldPc + 4 * i);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
